// File: bench/wb_cases.txt
# name pc instr addr sdata we mem rw cmd sel sys exx xcause xmtval, then expected commit:
# we rd wdata exc cause mtval redir rpc (hex; fields under a low flag are not compared)
alu_add      1000 00a28293 12345678 0        1 0 0 0 0 0 0 0 0         1 05 12345678 0 0 0 0 0
jal_pc4      2000 008000ef 00002008 0        1 0 0 0 3 0 0 0 0         1 01 00002004 0 0 0 0 0
sb_lane1     2004 007008a3 00000011 000000a5 0 1 1 0 0 0 0 0 0         0 00 0 0 0 0 0 0
sh_upper     2008 02701123 00000022 0000beef 0 1 1 0 0 0 0 0 0         0 00 0 0 0 0 0 0
sw_word      200c 02702823 00000030 cafef00d 0 1 1 0 0 0 0 0 0         0 00 0 0 0 0 0 0
lb_sign      2010 01100503 00000011 0        1 1 0 0 1 0 0 0 0         1 0a ffffffa5 0 0 0 0 0
lbu_zero     2014 01104583 00000011 0        1 1 0 0 1 0 0 0 0         1 0b 000000a5 0 0 0 0 0
lh_sign      2018 02201603 00000022 0        1 1 0 0 1 0 0 0 0         1 0c ffffbeef 0 0 0 0 0
lhu_zero     201c 02205683 00000022 0        1 1 0 0 1 0 0 0 0         1 0d 0000beef 0 0 0 0 0
lw_word      2020 03002703 00000030 0        1 1 0 0 1 0 0 0 0         1 0e cafef00d 0 0 0 0 0
lb_fill      2024 01700783 00000017 0        1 1 0 0 1 0 0 0 0         1 0f 00000005 0 0 0 0 0
lhu_fill     2028 03e05803 0000003e 0        1 1 0 0 1 0 0 0 0         1 10 00000f0f 0 0 0 0 0
lw_fill      202c 0fc02883 000000fc 0        1 1 0 0 1 0 0 0 0         1 11 3f3f3f3f 0 0 0 0 0
lh_misalign  3000 02101903 00000021 0        1 1 0 0 1 0 0 0 0         0 00 0 1 4 00000021 1 100
sw_misalign  3004 02702923 00000032 11223344 0 1 1 0 0 0 0 0 0         0 00 0 1 6 00000032 1 100
lw_fault     3008 00032983 f0000000 0        1 1 0 0 1 0 0 0 0         0 00 0 1 5 f0000000 1 100
sw_fault     300c 00732223 f0000004 00000055 0 1 1 0 0 0 0 0 0         0 00 0 1 7 f0000004 1 100
csrrw_mtvec  4000 30529a73 00000200 0        1 0 0 1 2 0 0 0 0         1 14 00000100 0 0 0 0 0
csrrs_mscr   4004 34032af3 000000f0 0        1 0 0 2 2 0 0 0 0         1 15 00000000 0 0 0 0 0
csrrc_mscr   4008 3403bb73 00000030 0        1 0 0 3 2 0 0 0 0         1 16 000000f0 0 0 0 0 0
csrrsi_zero  400c 34006bf3 00000000 0        1 0 0 2 2 0 0 0 0         1 17 000000c0 0 0 0 0 0
csrrwi_mscr  4010 340fdc73 00000000 0        1 0 0 1 2 0 0 0 0         1 18 000000c0 0 0 0 0 0
rd_mscratch  4014 34002cf3 00000000 0        1 0 0 2 2 0 0 0 0         1 19 0000001f 0 0 0 0 0
rd_mcause    4018 34202d73 00000000 0        1 0 0 2 2 0 0 0 0         1 1a 00000007 0 0 0 0 0
rd_mtval     401c 34302df3 00000000 0        1 0 0 2 2 0 0 0 0         1 1b f0000004 0 0 0 0 0
csr_unknown  4020 7c029e73 00000005 0        1 0 0 1 2 0 0 0 0         0 00 0 1 2 7c029e73 1 200
ecall        5000 00000073 00000000 0        0 0 0 0 0 1 0 0 0         0 00 0 1 b 00000000 1 200
mret_ecall   5100 30200073 00000000 0        0 0 0 0 0 1 0 0 0         0 00 0 0 0 0 1 5000
ebreak       6004 00100073 00000000 0        0 0 0 0 0 1 0 0 0         0 00 0 1 3 00006004 1 200
mret_ebreak  6100 30200073 00000000 0        0 0 0 0 0 1 0 0 0         0 00 0 0 0 0 1 6004
ex_over_mis  7000 00202e83 00000002 0        1 1 0 0 1 0 1 1 dead0000  0 00 0 1 1 dead0000 1 200
rd_mepc      7004 34102f73 00000000 0        1 0 0 2 2 0 0 0 0         1 1e 00007000 0 0 0 0 0

// File: verilog.f
verilog/rv_isa_pkg.sv
verilog/wb_pkg.sv
verilog/wb_lsu.sv
verilog/wb_csr_file.sv
verilog/wb_trap_arbiter.sv
verilog/wb_stage.sv
bench/wb_mem_model.sv
bench/tb_wb_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the write-back stage testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_wb_stage \
    --Mdir obj_dir \
    -o sim_wb_stage \
    -f verilog.f

./obj_dir/sim_wb_stage

// File: bench/tb_wb_stage.sv
`timescale 1ns/10ps

module tb_wb_stage;
    import rv_isa_pkg::*;
    import wb_pkg::*;

    localparam int    CLK_PERIOD  = 40;
    localparam int    RST_CYCLES  = 8;
    localparam int    CASE_CYCLES = 40;  // Watchdog budget per case
    localparam string CASES_FILE  = "bench/wb_cases.txt";

    logic       clk;
    logic       rst_n;
    logic       in_req;
    wb_instr_t  in_instr;
    logic       in_ack;
    wb_commit_t commit;
    dbus_req_t  dbus_req;
    dbus_rsp_t  dbus_rsp;
    logic       loaded = 1'b0;

    string      name_q[$];
    wb_instr_t  stim_q[$];
    wb_commit_t expect_q[$];

    wb_stage UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .in_req_i   (in_req),
        .in_instr_i (in_instr),
        .in_ack_o   (in_ack),
        .commit_o   (commit),
        .dbus_o     (dbus_req),
        .dbus_i     (dbus_rsp)
    );

    wb_mem_model u_mem (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .dbus_i  (dbus_req),
        .dbus_o  (dbus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Failure reporting and compares
    // --------------------------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input string what,
                              input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cause(input string name, input string what,
                               input cause_t exp, input cause_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input string what,
                             input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected x%0d actual x%0d", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %b actual %b", name, what, exp, act);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Cases file
    // --------------------------------------------------
    task automatic load_cases();
        int         fd;
        int         n;
        string      line;
        string      name;
        xlen_t      f [0:20];
        wb_instr_t  s;
        wb_commit_t e;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the cases file %s", CASES_FILE);
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // Blank or comment
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20]);
            if (n != 22) begin
                $display("malformed line in the cases file: %s", line);
                abort_run();
            end
            s              = '0;
            s.pc           = f[0];
            s.instr        = f[1];
            s.alu_result   = f[2];
            s.store_data   = f[3];
            s.rf_we        = f[4][0];
            s.mem_en       = f[5][0];
            s.mem_rw       = f[6][0];
            s.csr_cmd      = csr_cmd_e'(f[7][1:0]);
            s.sel_wb       = wb_sel_e'(f[8][1:0]);
            s.ecall_break  = f[9][0];
            s.ex_exception = f[10][0];
            s.ex_xcause    = f[11][3:0];
            s.ex_mtval     = f[12];
            e              = '0;
            e.rf_we        = f[13][0];
            e.rd           = f[14][4:0];
            e.wdata        = f[15];
            e.exception    = f[16][0];
            e.xcause       = f[17][3:0];
            e.mtval        = f[18];
            e.redirect     = f[19][0];
            e.redirect_pc  = f[20];
            name_q.push_back(name);
            stim_q.push_back(s);
            expect_q.push_back(e);
        end
        $fclose(fd);
        if (name_q.size() == 0) begin
            $display("the cases file holds no cases");
            abort_run();
        end
    endtask

    // One four-phase transfer, entered and left on a falling edge
    task automatic run_case(input int idx);
        string      name;
        wb_instr_t  stim;
        wb_commit_t exp;
        wb_commit_t got;
        int         cycles;
        logic       misaligned;
        name = name_q[idx];
        stim = stim_q[idx];
        exp  = expect_q[idx];
        misaligned = exp.exception && (exp.xcause == E_LOAD_ADDR_MISALIGNED
                                       || exp.xcause == E_STORE_AMO_ADDR_MISALIGNED);
        check_flag(name, "ack low before req", 1'b0, in_ack);
        in_instr = stim;
        in_req   = 1'b1;
        cycles   = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!in_ack);
        got = commit;
        if (!stim.mem_en || misaligned) begin  // No bus cycle on these
            check_flag(name, "ack on second edge", 1'b1, cycles == 2);
        end
        check_flag(name, "bus idle at commit", 1'b0, dbus_req.cyc);
        check_flag(name, "rf_we", exp.rf_we, got.rf_we);
        check_flag(name, "exception", exp.exception, got.exception);
        check_flag(name, "redirect", exp.redirect, got.redirect);
        if (exp.rf_we) begin
            check_reg(name, "rd", exp.rd, got.rd);
            check_word(name, "wdata", exp.wdata, got.wdata);
        end
        if (exp.exception) begin
            check_cause(name, "xcause", exp.xcause, got.xcause);
            check_word(name, "mtval", exp.mtval, got.mtval);
        end
        if (exp.redirect) begin
            check_word(name, "redirect_pc", exp.redirect_pc, got.redirect_pc);
        end
        @(negedge clk);
        check_flag(name, "ack held while req high", 1'b1, in_ack);
        in_req = 1'b0;
        do begin
            @(negedge clk);
        end while (in_ack);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        in_req   = 1'b0;
        in_instr = '0;
        rst_n    = 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        check_flag("reset", "ack", 1'b0, in_ack);
        check_flag("reset", "cyc", 1'b0, dbus_req.cyc);
        check_flag("reset", "stb", 1'b0, dbus_req.stb);
        check_flag("reset", "commit rf_we", 1'b0, commit.rf_we);
        check_flag("reset", "commit exception", 1'b0, commit.exception);
        check_flag("reset", "commit redirect", 1'b0, commit.redirect);
        check_word("reset", "commit wdata", '0, commit.wdata);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < name_q.size(); i++) begin
            run_case(i);
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (RST_CYCLES + CASE_CYCLES * name_q.size()) @(posedge clk);
        $display("timeout: the stage did not finish the cases in time");
        abort_run();
    end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/10ps

module wb_mem_model (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  wb_pkg::dbus_req_t dbus_i,
    output wb_pkg::dbus_rsp_t dbus_o
);
    import rv_isa_pkg::*;

    localparam xlen_t FAULT_BASE = 32'hF000_0000;  // Everything above answers err

    xlen_t       mem [0:63];
    logic        busy_q;
    logic [1:0]  wait_q;
    logic        ack_q;
    logic        err_q;
    xlen_t       dat_q;
    logic [5:0]  idx;
    logic        fault;

    initial begin
        void'($urandom(85));
    end

    assign idx    = dbus_i.addr[7:2];  // 256 bytes, wraps above
    assign fault  = dbus_i.addr >= FAULT_BASE;
    assign dbus_o = '{dat: dat_q, ack: ack_q, err: err_q};

    // --------------------------------------------------
    // Slave side of a classic cycle
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            wait_q <= '0;
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            dat_q  <= '0;
            for (int k = 0; k < 64; k++) begin
                mem[k] <= xlen_t'(k) * 32'h0101_0101;  // Word k repeats k in every byte
            end
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            if (dbus_i.cyc && dbus_i.stb && !ack_q && !err_q) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= 2'($urandom_range(3, 0));  // Wait states for this cycle
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    busy_q <= 1'b0;
                    if (fault) begin
                        err_q <= 1'b1;
                    end else begin
                        ack_q <= 1'b1;
                        dat_q <= mem[idx];
                        if (dbus_i.we) begin
                            for (int i = 0; i < 4; i++) begin
                                if (dbus_i.sel[i]) begin
                                    mem[idx][8*i +: 8] <= dbus_i.dat[8*i +: 8];
                                end
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

// File: verilog/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               in_req_i,
    input  wb_pkg::wb_instr_t  in_instr_i,
    output logic               in_ack_o,
    output wb_pkg::wb_commit_t commit_o,
    output wb_pkg::dbus_req_t  dbus_o,
    input  wb_pkg::dbus_rsp_t  dbus_i
);
    import rv_isa_pkg::*;
    import wb_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    wb_instr_t  rec_q;
    wb_commit_t commit_d;
    logic       lsu_start;
    logic       lsu_done;
    logic       lsu_misaligned;
    logic       lsu_ld_err;
    logic       lsu_st_err;
    xlen_t      lsu_rdata;
    xlen_t      csr_rdata;
    xlen_t      csr_wdata;
    logic       csr_illegal;
    xlen_t      mtvec;
    xlen_t      mepc;
    logic       exception;
    cause_t     xcause;
    xlen_t      mtval;
    logic       mret;
    logic       enter_done;
    xlen_t      wb_wdata;

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    // Faulted records never reach the bus
    assign lsu_start  = state_q == EXEC && rec_q.mem_en && !rec_q.ex_exception;
    assign enter_done = (state_q == EXEC && (!lsu_start || lsu_done))
                        || (state_q == MEM && lsu_done);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: if (in_req_i) state_d = EXEC;
            EXEC: state_d = (lsu_start && !lsu_done) ? MEM : DONE;
            MEM:  if (lsu_done) state_d = DONE;
            DONE: if (!in_req_i) state_d = IDLE;  // Four-phase return
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && in_req_i) rec_q <= in_instr_i;
    end

    assign in_ack_o = state_q == DONE;

    wb_lsu u_lsu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (lsu_start),
        .addr_i       (rec_q.alu_result),
        .wdata_i      (rec_q.store_data),
        .store_i      (rec_q.mem_rw),
        .funct3_i     (rec_q.instr[14:12]),
        .rdata_o      (lsu_rdata),
        .done_o       (lsu_done),
        .misaligned_o (lsu_misaligned),
        .ld_err_o     (lsu_ld_err),
        .st_err_o     (lsu_st_err),
        .dbus_o       (dbus_o),
        .dbus_i       (dbus_i)
    );

    // Immediate forms take the zero-extended rs1 field
    assign csr_wdata = rec_q.instr[14] ? {27'b0, rec_q.instr[19:15]} : rec_q.alu_result;

    wb_csr_file u_csr (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .addr_i       (rec_q.instr[31:20]),
        .cmd_i        (rec_q.csr_cmd),
        .wdata_i      (csr_wdata),
        .rs1_zero_i   (rec_q.instr[19:15] == 5'd0),
        .commit_i     (enter_done),
        .trap_i       (exception),
        .trap_pc_i    (rec_q.pc),
        .trap_cause_i (xcause),
        .trap_mtval_i (mtval),
        .rdata_o      (csr_rdata),
        .illegal_o    (csr_illegal),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc)
    );

    wb_trap_arbiter u_arb (
        .instr_i       (rec_q),
        .misaligned_i  (lsu_misaligned),
        .ld_err_i      (lsu_ld_err),
        .st_err_i      (lsu_st_err),
        .csr_illegal_i (csr_illegal),
        .exception_o   (exception),
        .xcause_o      (xcause),
        .mtval_o       (mtval),
        .mret_o        (mret)
    );

    // --------------------------------------------------
    // Write-back select and commit
    // --------------------------------------------------
    always_comb begin
        unique case (rec_q.sel_wb)
            SEL_ALU: wb_wdata = rec_q.alu_result;
            SEL_LSU: wb_wdata = lsu_rdata;
            SEL_CSR: wb_wdata = csr_rdata;  // Old value, before the update
            default: wb_wdata = rec_q.pc + 32'd4;
        endcase
    end

    assign commit_d = '{rf_we:       rec_q.rf_we && !exception,
                        rd:          rec_q.instr[11:7],
                        wdata:       wb_wdata,
                        exception:   exception,
                        xcause:      xcause,
                        mtval:       mtval,
                        redirect:    exception || mret,
                        redirect_pc: exception ? mtvec : mepc};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o <= '0;
        end else if (enter_done) begin
            commit_o <= commit_d;  // Held through DONE
        end
    end

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(in_ack_o) |-> in_req_i)
        else $error("ack raised without a pending req");

endmodule

// File: verilog/wb_trap_arbiter.sv
`timescale 1ns/10ps

module wb_trap_arbiter (
    input  wb_pkg::wb_instr_t  instr_i,
    input  logic               misaligned_i,
    input  logic               ld_err_i,
    input  logic               st_err_i,
    input  logic               csr_illegal_i,
    output logic               exception_o,
    output rv_isa_pkg::cause_t xcause_o,
    output rv_isa_pkg::xlen_t  mtval_o,
    output logic               mret_o
);
    import rv_isa_pkg::*;

    logic        ecall;
    logic        ebreak;
    logic [11:0] funct12;

    // --------------------------------------------------
    // SYSTEM decode
    // --------------------------------------------------
    assign funct12 = instr_i.instr[31:20];
    assign ecall   = instr_i.ecall_break && funct12 == F12_ECALL;
    assign ebreak  = instr_i.ecall_break && funct12 == F12_EBREAK;
    assign mret_o  = instr_i.ecall_break && funct12 == F12_MRET;

    assign exception_o = |{instr_i.ex_exception, misaligned_i, ld_err_i, st_err_i,
                           csr_illegal_i, ecall, ebreak};

    // Highest priority first
    always_comb begin
        if (instr_i.ex_exception) begin
            xcause_o = instr_i.ex_xcause;  // Earlier stage already chose
            mtval_o  = instr_i.ex_mtval;
        end else if (misaligned_i) begin
            xcause_o = instr_i.instr[5] ? E_STORE_AMO_ADDR_MISALIGNED
                                        : E_LOAD_ADDR_MISALIGNED;  // Opcode bit 5
            mtval_o  = instr_i.alu_result;
        end else if (ld_err_i) begin
            xcause_o = E_LOAD_ACCESS_FAULT;
            mtval_o  = instr_i.alu_result;
        end else if (st_err_i) begin
            xcause_o = E_STORE_AMO_ACCESS_FAULT;
            mtval_o  = instr_i.alu_result;
        end else if (csr_illegal_i) begin
            xcause_o = E_ILLEGAL_INST;
            mtval_o  = instr_i.instr;      // Faulting instruction word
        end else if (ecall) begin
            xcause_o = E_ECALL_FROM_M;
            mtval_o  = '0;
        end else if (ebreak) begin
            xcause_o = E_BREAKPOINT;
            mtval_o  = instr_i.pc;
        end else begin
            xcause_o = '0;
            mtval_o  = '0;
        end
    end

endmodule

// File: verilog/wb_csr_file.sv
`timescale 1ns/10ps

module wb_csr_file (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::csr_addr_t addr_i,
    input  wb_pkg::csr_cmd_e      cmd_i,
    input  rv_isa_pkg::xlen_t     wdata_i,
    input  logic                  rs1_zero_i,
    input  logic                  commit_i,
    input  logic                  trap_i,
    input  rv_isa_pkg::xlen_t     trap_pc_i,
    input  rv_isa_pkg::cause_t    trap_cause_i,
    input  rv_isa_pkg::xlen_t     trap_mtval_i,
    output rv_isa_pkg::xlen_t     rdata_o,
    output logic                  illegal_o,
    output rv_isa_pkg::xlen_t     mtvec_o,
    output rv_isa_pkg::xlen_t     mepc_o
);
    import rv_isa_pkg::*;
    import wb_pkg::*;

    xlen_t  mtvec_q;
    xlen_t  mscratch_q;
    xlen_t  mepc_q;
    cause_t mcause_q;
    xlen_t  mtval_q;
    logic   hit;
    logic   wr_en;
    xlen_t  new_val;

    assign mtvec_o = {mtvec_q[31:2], 2'b00};  // Direct mode only
    assign mepc_o  = {mepc_q[31:2], 2'b00};

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    always_comb begin
        hit = 1'b1;
        unique case (addr_i)
            MTVEC:    rdata_o = mtvec_o;
            MSCRATCH: rdata_o = mscratch_q;
            MEPC:     rdata_o = mepc_o;
            MCAUSE:   rdata_o = {28'b0, mcause_q};
            MTVAL:    rdata_o = mtval_q;
            default: begin
                hit     = 1'b0;
                rdata_o = '0;
            end
        endcase
    end

    assign illegal_o = (cmd_i != CSR_NONE) && !hit;

    // Read-modify-write value
    always_comb begin
        unique case (cmd_i)
            CSR_SET:   new_val = rdata_o | wdata_i;
            CSR_CLEAR: new_val = rdata_o & ~wdata_i;
            default:   new_val = wdata_i;
        endcase
    end

    // Set/clear with rs1 = x0 reads only
    assign wr_en = commit_i && !trap_i && cmd_i != CSR_NONE
                   && !(cmd_i != CSR_WRITE && rs1_zero_i);

    // --------------------------------------------------
    // Update
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtvec_q    <= MTVEC_RESET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (commit_i && trap_i) begin
            mepc_q   <= trap_pc_i;
            mcause_q <= trap_cause_i;
            mtval_q  <= trap_mtval_i;
        end else if (wr_en) begin
            unique case (addr_i)
                MTVEC:    mtvec_q    <= new_val;
                MSCRATCH: mscratch_q <= new_val;
                MEPC:     mepc_q     <= new_val;
                MCAUSE:   mcause_q   <= new_val[3:0];  // Only exception codes kept
                MTVAL:    mtval_q    <= new_val;
                default:  ;
            endcase
        end
    end

    a_no_write_on_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_i && illegal_o |-> trap_i)
        else $error("illegal CSR access committed without a trap");

endmodule

// File: verilog/wb_lsu.sv
`timescale 1ns/10ps

module wb_lsu (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  rv_isa_pkg::xlen_t   addr_i,
    input  rv_isa_pkg::xlen_t   wdata_i,
    input  logic                store_i,
    input  rv_isa_pkg::funct3_t funct3_i,
    output rv_isa_pkg::xlen_t   rdata_o,
    output logic                done_o,
    output logic                misaligned_o,
    output logic                ld_err_o,
    output logic                st_err_o,
    output wb_pkg::dbus_req_t   dbus_o,
    input  wb_pkg::dbus_rsp_t   dbus_i
);
    import rv_isa_pkg::*;

    logic       busy_q;
    logic       misaligned;
    logic [3:0] sel_d;
    xlen_t      dat_d;
    xlen_t      addr_q;
    xlen_t      dat_q;
    logic [3:0] sel_q;
    logic       we_q;
    funct3_t    f3_q;
    xlen_t      shifted;
    logic       bus_end;

    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------
    always_comb begin
        unique case (funct3_i[1:0])
            SZ_BYTE: begin
                misaligned = 1'b0;
                sel_d      = 4'b0001 << addr_i[1:0];
                dat_d      = {4{wdata_i[7:0]}};
            end
            SZ_HALF: begin
                misaligned = addr_i[0];
                sel_d      = 4'b0011 << addr_i[1:0];
                dat_d      = {2{wdata_i[15:0]}};
            end
            default: begin  // Word, funct3 11 is treated the same
                misaligned = |addr_i[1:0];
                sel_d      = 4'b1111;
                dat_d      = wdata_i;
            end
        endcase
    end

    assign misaligned_o = start_i & misaligned;  // Reported with no bus cycle
    assign bus_end      = busy_q & (dbus_i.ack | dbus_i.err);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (start_i && !misaligned) begin
            busy_q <= 1'b1;
        end else if (bus_end) begin
            busy_q <= 1'b0;                      // cyc/stb drop the cycle after
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && !misaligned) begin
            addr_q <= addr_i;
            dat_q  <= dat_d;
            sel_q  <= sel_d;
            we_q   <= store_i;
            f3_q   <= funct3_i;
        end
    end

    assign dbus_o = '{addr: addr_q, dat: dat_q, sel: sel_q,
                      cyc: busy_q, stb: busy_q, we: we_q};

    // --------------------------------------------------
    // Response
    // --------------------------------------------------
    assign done_o   = misaligned_o | bus_end;
    assign ld_err_o = busy_q & dbus_i.err & ~we_q;
    assign st_err_o = busy_q & dbus_i.err & we_q;

    // Lane to bit 0, then extend unless funct3 asks for unsigned
    always_comb begin
        shifted = dbus_i.dat >> {addr_q[1:0], 3'b000};
        unique case (f3_q[1:0])
            SZ_BYTE: rdata_o = {{24{shifted[7] & ~f3_q[2]}}, shifted[7:0]};
            SZ_HALF: rdata_o = {{16{shifted[15] & ~f3_q[2]}}, shifted[15:0]};
            default: rdata_o = shifted;
        endcase
    end

    a_stb_lanes: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dbus_o.stb |-> dbus_o.cyc && dbus_o.sel != 4'b0000)
        else $error("stb without cyc or byte lanes");

endmodule

// File: verilog/wb_pkg.sv
package wb_pkg;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_cmd_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        SEL_ALU = 2'd0,
        SEL_LSU = 2'd1,
        SEL_CSR = 2'd2,
        SEL_PC4 = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        EXEC = 2'd1,
        MEM  = 2'd2,
        DONE = 2'd3
    } seq_state_e;

    // --------------------------------------------------
    // Records crossing the stage boundary
    // --------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::xlen_t  pc;
        rv_isa_pkg::xlen_t  instr;
        rv_isa_pkg::xlen_t  alu_result;   // Also the memory address
        rv_isa_pkg::xlen_t  store_data;
        logic               rf_we;
        logic               mem_en;
        logic               mem_rw;       // 1 for store
        csr_cmd_e           csr_cmd;
        wb_sel_e            sel_wb;
        logic               ecall_break;  // SYSTEM: ecall, ebreak or mret
        logic               ex_exception;
        rv_isa_pkg::cause_t ex_xcause;
        rv_isa_pkg::xlen_t  ex_mtval;
    } wb_instr_t;

    typedef struct packed {
        logic                  rf_we;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xlen_t     wdata;
        logic                  exception;
        rv_isa_pkg::cause_t    xcause;
        rv_isa_pkg::xlen_t     mtval;
        logic                  redirect;
        rv_isa_pkg::xlen_t     redirect_pc;
    } wb_commit_t;

    // Wishbone classic data bus
    typedef struct packed {
        rv_isa_pkg::xlen_t addr;
        rv_isa_pkg::xlen_t dat;
        logic [3:0]        sel;
        logic              cyc;
        logic              stb;
        logic              we;
    } dbus_req_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t dat;
        logic              ack;
        logic              err;
    } dbus_rsp_t;

endpackage

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // --------------------------------------------------
    // Widths fixed by the ISA
    // --------------------------------------------------
    typedef logic [31:0] xlen_t;     // Data or address word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  cause_t;    // Exception code, no interrupts here
    typedef logic [2:0]  funct3_t;

    // Access size, funct3 bits 1:0 of loads and stores
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // --------------------------------------------------
    // Machine trap CSRs
    // --------------------------------------------------
    localparam csr_addr_t MTVEC    = 12'h305;
    localparam csr_addr_t MSCRATCH = 12'h340;
    localparam csr_addr_t MEPC     = 12'h341;
    localparam csr_addr_t MCAUSE   = 12'h342;
    localparam csr_addr_t MTVAL    = 12'h343;

    localparam xlen_t MTVEC_RESET = 32'h0000_0100;

    // mret encoding in the funct12 field of a SYSTEM instruction
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // --------------------------------------------------
    // Exception causes
    // --------------------------------------------------
    localparam cause_t E_ILLEGAL_INST              = 4'd2;
    localparam cause_t E_BREAKPOINT                = 4'd3;
    localparam cause_t E_LOAD_ADDR_MISALIGNED      = 4'd4;
    localparam cause_t E_LOAD_ACCESS_FAULT         = 4'd5;
    localparam cause_t E_STORE_AMO_ADDR_MISALIGNED = 4'd6;
    localparam cause_t E_STORE_AMO_ACCESS_FAULT    = 4'd7;
    localparam cause_t E_ECALL_FROM_M              = 4'd11;

endpackage
